/* tb/cp0_testdata.txt */
# name mtc0 eret tlbwi tlbp tlbr reg sel wdata exc exc_pc bd mem_va lookup_vpn2 stall
#   then expected: rdata jump jump_pc lookup_found (op bits and reg/sel decimal, rest hex)
status_rst  0 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00400000 0 00000000 0
prid        0 0 0 0 0 15 0 00000000 0000 00000000 0 00000000 7ffff 0 00018003 0 00000000 0
pagemask    1 0 0 0 0 5  0 ffffffff 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
status_wr   1 0 0 0 0 12 0 ffffffff 0000 00000000 0 00000000 7ffff 0 00400000 0 00000000 0
status_rd   0 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 1040ff17 0 00000000 0
status_boot 1 0 0 0 0 12 0 00400000 0000 00000000 0 00000000 7ffff 0 1040ff17 0 00000000 0
epc_wr      1 0 0 0 0 14 0 12345678 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
epc_rd      0 0 0 0 0 14 0 00000000 0000 00000000 0 00000000 7ffff 0 12345678 0 00000000 0
entryhi_wr  1 0 0 0 0 10 0 ffffffff 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
entryhi_rd  0 0 0 0 0 10 0 00000000 0000 00000000 0 00000000 7ffff 0 ffffe0ff 0 00000000 0
ebase_wr    1 0 0 0 0 15 1 00001000 0000 00000000 0 00000000 7ffff 0 80000000 0 00000000 0
ebase_rd    0 0 0 0 0 15 1 00000000 0000 00000000 0 00000000 7ffff 0 80001000 0 00000000 0
syscall     0 0 0 0 0 13 0 00000000 0020 bfc01000 0 00000000 7ffff 0 00000000 1 bfc00380 0
cause_rd    0 0 0 0 0 13 0 00000000 0000 00000000 0 00000000 7ffff 0 00000020 0 00000000 0
exl_rd      0 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00400002 0 00000000 0
epc_sys     0 0 0 0 0 14 0 00000000 0000 00000000 0 00000000 7ffff 0 bfc01000 0 00000000 0
eret        0 1 0 0 0 14 0 00000000 0000 00000000 0 00000000 7ffff 0 bfc01000 1 bfc01000 0
exl_clr     0 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00400000 0 00000000 0
sys_bd      0 0 0 0 0 13 0 00000000 0020 bfc02004 1 00000000 7ffff 0 00000020 1 bfc00380 0
epc_bd      0 0 0 0 0 14 0 00000000 0000 00000000 0 00000000 7ffff 0 bfc02000 0 00000000 0
eret_bd     0 1 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00400002 1 bfc02000 0
bev_clr     1 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00400000 0 00000000 0
refill      0 0 0 0 0 8  0 00000000 0240 00400000 0 00abc123 7ffff 0 00000000 1 80001000 0
badva_rd    0 0 0 0 0 8  0 00000000 0000 00000000 0 00000000 7ffff 0 00abc123 0 00000000 0
vpn2_rd     0 0 0 0 0 10 0 00000000 0000 00000000 0 00000000 7ffff 0 00abc0ff 0 00000000 0
eret_refill 0 1 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00000002 1 00400000 0
lo0_wr      1 0 0 0 0 2  0 0048d15e 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
lo1_wr      1 0 0 0 0 3  0 019e2692 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
hi_wr       1 0 0 0 0 10 0 24680005 0000 00000000 0 00000000 7ffff 0 00abc0ff 0 00000000 0
idx_wr      1 0 0 0 0 0  0 00000003 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0
tlbwi       0 0 1 0 0 0  0 00000000 0000 00000000 0 00000000 12340 0 00000003 0 00000000 0
lookup_hit  0 0 0 0 0 0  0 00000000 0000 00000000 0 00000000 12340 0 00000003 0 00000000 1
asid_chg    1 0 0 0 0 10 0 24680007 0000 00000000 0 00000000 12340 0 24680005 0 00000000 1
lookup_miss 0 0 0 0 0 10 0 00000000 0000 00000000 0 00000000 12340 0 24680007 0 00000000 0
lo0_g       1 0 0 0 0 2  0 0048d15f 0000 00000000 0 00000000 7ffff 0 0048d15e 0 00000000 0
lo1_g       1 0 0 0 0 3  0 019e2693 0000 00000000 0 00000000 7ffff 0 019e2692 0 00000000 0
hi_g        1 0 0 0 0 10 0 3579a009 0000 00000000 0 00000000 7ffff 0 24680007 0 00000000 0
idx4        1 0 0 0 0 0  0 00000004 0000 00000000 0 00000000 7ffff 0 00000003 0 00000000 0
tlbwi_g     0 0 1 0 0 0  0 00000000 0000 00000000 0 00000000 7ffff 0 00000004 0 00000000 0
asid_other  1 0 0 0 0 10 0 3579a001 0000 00000000 0 00000000 1abcd 0 3579a009 0 00000000 1
lookup_g    0 0 0 0 0 10 0 00000000 0000 00000000 0 00000000 1abcd 0 3579a001 0 00000000 1
hi_probe    1 0 0 0 0 10 0 24680005 0000 00000000 0 00000000 7ffff 0 3579a001 0 00000000 0
tlbp_hit    0 0 0 1 0 0  0 00000000 0000 00000000 0 00000000 7ffff 0 00000004 0 00000000 0
probe_idx   0 0 0 0 0 0  0 00000000 0000 00000000 0 00000000 7ffff 0 00000003 0 00000000 0
hi_miss     1 0 0 0 0 10 0 11110005 0000 00000000 0 00000000 7ffff 0 24680005 0 00000000 0
tlbp_miss   0 0 0 1 0 0  0 00000000 0000 00000000 0 00000000 7ffff 0 00000003 0 00000000 0
probe_p     0 0 0 0 0 0  0 00000000 0000 00000000 0 00000000 7ffff 0 80000003 0 00000000 0
tlbr        0 0 0 0 1 10 0 00000000 0000 00000000 0 00000000 7ffff 0 11110005 0 00000000 0
tlbr_hi     0 0 0 0 0 10 0 00000000 0000 00000000 0 00000000 7ffff 0 24680005 0 00000000 0
tlbr_lo0    0 0 0 0 0 2  0 00000000 0000 00000000 0 00000000 7ffff 0 0048d15e 0 00000000 0
tlbr_lo1    0 0 0 0 0 3  0 00000000 0000 00000000 0 00000000 7ffff 0 019e2692 0 00000000 0
stall_exc   0 0 0 0 0 13 0 00000000 0020 00001000 0 00000000 7ffff 1 00000008 0 80001180 0
stall_mtc0  1 0 0 0 0 14 0 deadbeef 0000 00000000 0 00000000 7ffff 1 00400000 0 00000000 0
stall_epc   0 0 0 0 0 14 0 00000000 0000 00000000 0 00000000 7ffff 0 00400000 0 00000000 0
stall_exl   0 0 0 0 0 12 0 00000000 0000 00000000 0 00000000 7ffff 0 00000000 0 00000000 0

/* all.f */
+incdir+common
common/cp0_pkg.sv
tlb/tlb_match.sv
tlb/tlb_array.sv
design/cp0_regs.sv
design/except_ctrl.sv
design/cp0_top.sv
tb/cp0_tb.sv

/* Bender.yml */
package:
  name: cp0

sources:
  - include_dirs:
      - common
    files:
      - common/cp0_pkg.sv
      - tlb/tlb_match.sv
      - tlb/tlb_array.sv
      - design/cp0_regs.sv
      - design/except_ctrl.sv
      - design/cp0_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/cp0_tb.sv

/* tb/cp0_tb.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module cp0_tb import cp0_pkg::*; ();

    // one line of the data file
    typedef struct packed {
        cp0_op_t     op;
        logic [31:0] wdata;
        except_t     exc;
        logic [31:0] exc_pc;
        logic        exc_bd;
        logic [31:0] mem_va;
        logic [18:0] lookup_vpn2;
        logic        stall;
        logic [31:0] exp_rdata;
        logic        exp_jump;
        logic [31:0] exp_jump_pc;
        logic        exp_found;
    } vector_t;

    logic        clk;
    logic        rst;
    logic        stall;
    cp0_op_t     op;
    logic [31:0] wdata;
    except_t     exc;
    logic [31:0] exc_pc;
    logic        exc_bd;
    logic [31:0] mem_va;
    logic [18:0] lookup_vpn2;
    logic [31:0] rdata;
    logic        jump;
    logic [31:0] jump_pc;
    logic        kernel_mode;
    logic        cp0_usable;
    logic        lookup_found;
    tlb_entry_t  lookup_entry;

    vector_t     vectors [$];
    string       names [$];
    logic        loaded;

    cp0_top uut (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .op           (op),
        .wdata        (wdata),
        .exc          (exc),
        .exc_pc       (exc_pc),
        .exc_bd       (exc_bd),
        .mem_va       (mem_va),
        .lookup_vpn2  (lookup_vpn2),
        .rdata        (rdata),
        .jump         (jump),
        .jump_pc      (jump_pc),
        .kernel_mode  (kernel_mode),
        .cp0_usable   (cp0_usable),
        .lookup_found (lookup_found),
        .lookup_entry (lookup_entry)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic load_vectors();
        integer      fd;
        integer      count;
        integer      m, e, w, p, r, ra, sl, bd, st, ej, ef;
        logic [31:0] wd, ex, pc, va, lv, er, ejp;
        string       line;
        string       name;
        vector_t     v;
        fd = $fopen("tb/cp0_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test data file tb/cp0_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            count = $fgets(line, fd);
            // skip comments and blank lines
            if (count > 0 && line.len() > 1 && line[0] != "#") begin
                count = $sscanf(line,
                    "%s %d %d %d %d %d %d %d %h %h %h %d %h %h %d %h %d %h %d",
                    name, m, e, w, p, r, ra, sl, wd, ex, pc, bd, va, lv, st,
                    er, ej, ejp, ef);
                if (count != 19) begin
                    abort_run({"malformed line in the test data file: ", line});
                end
                v.op = '{mtc0_en: m[0], eret: e[0], tlbwi: w[0], tlbp: p[0], tlbr: r[0],
                         reg_addr: ra[4:0], sel: sl[2:0]};
                v.wdata       = wd;
                v.exc         = except_t'(ex[14:0]);
                v.exc_pc      = pc;
                v.exc_bd      = bd[0];
                v.mem_va      = va;
                v.lookup_vpn2 = lv[18:0];
                v.stall       = st[0];
                v.exp_rdata   = er;
                v.exp_jump    = ej[0];
                v.exp_jump_pc = ejp;
                v.exp_found   = ef[0];
                vectors.push_back(v);
                names.push_back(name);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            abort_run("the test data file holds no vectors");
        end
    endtask

    task automatic apply_vector(input vector_t v);
        stall       = v.stall;
        op          = v.op;
        wdata       = v.wdata;
        exc         = v.exc;
        exc_pc      = v.exc_pc;
        exc_bd      = v.exc_bd;
        mem_va      = v.mem_va;
        lookup_vpn2 = v.lookup_vpn2;
    endtask

    task automatic verify_outputs(input string test, input vector_t v);
        status_t exp_status;
        logic    exp_kernel;
        exp_status = v.exp_rdata;
        check_value(test, "rdata", v.exp_rdata, rdata);
        check_value(test, "jump", {31'd0, v.exp_jump}, {31'd0, jump});
        check_value(test, "jump_pc", v.exp_jump_pc, jump_pc);
        check_value(test, "lookup_found", {31'd0, v.exp_found}, {31'd0, lookup_found});
        // a status read shows the fields that decide the mode
        if (v.op.reg_addr == `CP0_REG_STATUS) begin
            exp_kernel = exp_status.EXL | exp_status.ERL | (|v.exc) | !exp_status.UM;
            check_value(test, "kernel_mode", {31'd0, exp_kernel}, {31'd0, kernel_mode});
            check_value(test, "cp0_usable", {31'd0, exp_kernel | exp_status.CU0},
                        {31'd0, cp0_usable});
        end
        // a hit returns the entry holding the looked-up page pair
        if (v.exp_found) begin
            check_value(test, "lookup_entry.VPN2", {13'd0, v.lookup_vpn2},
                        {13'd0, lookup_entry.VPN2});
        end
    endtask

    // bound by the number of vectors plus reset and some slack
    initial begin
        wait (loaded === 1'b1);
        #((vectors.size() + 20) * 100);
        abort_run("watchdog timeout, the test sequence did not finish in time");
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        stall       = 1'b0;
        op          = '0;
        wdata       = '0;
        exc         = '0;
        exc_pc      = '0;
        exc_bd      = 1'b0;
        mem_va      = '0;
        lookup_vpn2 = '0;
        loaded      = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        // drive 10 ns after the edge, sample shortly before the next one
        foreach (vectors[i]) begin
            apply_vector(vectors[i]);
            #70;
            verify_outputs(names[i], vectors[i]);
            @(posedge clk);
            #10;
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* design/cp0_top.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module cp0_top import cp0_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  cp0_op_t     op,
    input  logic [31:0] wdata,
    input  except_t     exc,
    input  logic [31:0] exc_pc,
    input  logic        exc_bd,
    input  logic [31:0] mem_va,
    input  logic [18:0] lookup_vpn2,
    output logic [31:0] rdata,
    output logic        jump,
    output logic [31:0] jump_pc,
    output logic        kernel_mode,
    output logic        cp0_usable,
    output logic        lookup_found,
    output tlb_entry_t  lookup_entry
);

    except_state_t         estate;
    status_t               status;
    entryhi_t              entryhi;
    logic [31:0]           epc;
    logic [31:0]           errorepc;
    logic [31:0]           ebase;
    logic [`TLB_IDX_W-1:0] index;
    logic                  tlb_we;
    tlb_entry_t            tlb_wentry;
    logic                  probe_hit;
    logic [`TLB_IDX_W-1:0] probe_index;
    tlb_entry_t            read_entry;

    cp0_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .op          (op),
        .wdata       (wdata),
        .estate      (estate),
        .probe_hit   (probe_hit),
        .probe_index (probe_index),
        .read_entry  (read_entry),
        .rdata       (rdata),
        .status      (status),
        .epc         (epc),
        .errorepc    (errorepc),
        .ebase       (ebase),
        .entryhi     (entryhi),
        .index       (index),
        .tlb_we      (tlb_we),
        .tlb_wentry  (tlb_wentry)
    );

    except_ctrl u_except (
        .op          (op),
        .stall       (stall),
        .exc         (exc),
        .exc_pc      (exc_pc),
        .exc_bd      (exc_bd),
        .mem_va      (mem_va),
        .status      (status),
        .epc         (epc),
        .errorepc    (errorepc),
        .ebase       (ebase),
        .estate      (estate),
        .jump        (jump),
        .jump_pc     (jump_pc),
        .kernel_mode (kernel_mode),
        .cp0_usable  (cp0_usable)
    );

    // probe key and lookup asid both come from entryhi
    tlb_array u_tlb (
        .clk          (clk),
        .rst          (rst),
        .we           (tlb_we),
        .windex       (index),
        .wentry       (tlb_wentry),
        .asid         (entryhi.ASID),
        .probe_vpn2   (entryhi.VPN2),
        .lookup_vpn2  (lookup_vpn2),
        .rindex       (index),
        .probe_hit    (probe_hit),
        .probe_index  (probe_index),
        .lookup_found (lookup_found),
        .lookup_entry (lookup_entry),
        .read_entry   (read_entry)
    );

endmodule

/* design/except_ctrl.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module except_ctrl import cp0_pkg::*; (
    input  cp0_op_t       op,
    input  logic          stall,
    input  except_t       exc,
    input  logic [31:0]   exc_pc,
    input  logic          exc_bd,
    input  logic [31:0]   mem_va,
    input  status_t       status,
    input  logic [31:0]   epc,
    input  logic [31:0]   errorepc,
    input  logic [31:0]   ebase,
    output except_state_t estate,
    output logic          jump,
    output logic [31:0]   jump_pc,
    output logic          kernel_mode,
    output logic          cp0_usable
);

    logic        any_exc;
    logic        if_fault;
    logic        tlb_refill;
    logic [31:0] trap_base;
    logic [4:0]  code;

    assign any_exc  = |exc;
    assign if_fault = exc.if_adel | exc.if_tlbl;

    // refill only when the miss was not caught by a fetch fault first
    assign tlb_refill = (exc.if_tlbl & exc.if_tlbrf) |
                        (!if_fault & (exc.ex_tlbl | exc.ex_tlbs) & exc.ex_tlbrf);

    assign trap_base = status.BEV ? `BOOT_TRAP_BASE : ebase;

    always_comb begin
        if (exc.if_adel | exc.ex_adel)      code = `EXC_ADEL;
        else if (exc.ex_ades)               code = `EXC_ADES;
        else if (exc.if_tlbl | exc.ex_tlbl) code = `EXC_TLBL;
        else if (exc.ex_tlbs)               code = `EXC_TLBS;
        else if (exc.ex_tlbm)               code = `EXC_MOD;
        else if (exc.id_syscall)            code = `EXC_SYS;
        else if (exc.id_break)              code = `EXC_BP;
        else if (exc.id_ri)                 code = `EXC_RI;
        else if (exc.id_cpu)                code = `EXC_CPU;
        else if (exc.ex_ov)                 code = `EXC_OV;
        else                                code = `EXC_TR;
    end

    assign estate.take      = any_exc;
    assign estate.ret       = op.eret && !any_exc;
    assign estate.exccode   = code;
    assign estate.bd        = exc_bd;
    assign estate.epc       = exc_bd ? exc_pc - 32'd4 : exc_pc;
    assign estate.set_badva = if_fault | exc.ex_adel | exc.ex_ades |
                              exc.ex_tlbl | exc.ex_tlbs | exc.ex_tlbm;
    assign estate.set_vpn2  = exc.if_tlbl | exc.ex_tlbl | exc.ex_tlbs | exc.ex_tlbm;
    assign estate.badva     = if_fault ? exc_pc : mem_va;

    assign jump = (estate.take || estate.ret) && !stall;

    always_comb begin
        if (estate.take) begin
            if (tlb_refill && !status.EXL) begin
                jump_pc = trap_base + `VEC_REFILL;
            end else begin
                jump_pc = trap_base + `VEC_GENERAL;
            end
        end else if (estate.ret) begin
            jump_pc = status.ERL ? errorepc : epc;
        end else begin
            jump_pc = 32'd0;
        end
    end

    assign kernel_mode = status.EXL | status.ERL | any_exc | !status.UM;
    assign cp0_usable  = kernel_mode | status.CU0;

endmodule

/* design/cp0_regs.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module cp0_regs import cp0_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  cp0_op_t               op,
    input  logic [31:0]           wdata,
    input  except_state_t         estate,
    input  logic                  probe_hit,
    input  logic [`TLB_IDX_W-1:0] probe_index,
    input  tlb_entry_t            read_entry,
    output logic [31:0]           rdata,
    output status_t               status,
    output logic [31:0]           epc,
    output logic [31:0]           errorepc,
    output logic [31:0]           ebase,
    output entryhi_t              entryhi,
    output logic [`TLB_IDX_W-1:0] index,
    output logic                  tlb_we,
    output tlb_entry_t            tlb_wentry
);

    index_t      index_q;
    entrylo_t    entrylo0_q;
    entrylo_t    entrylo1_q;
    context_t    context_q;
    logic [31:0] badva_q;
    entryhi_t    entryhi_q;
    status_t     status_q;
    cause_t      cause_q;
    logic [31:0] epc_q;
    logic [31:0] ebase_q;
    logic [31:0] errorepc_q;

    // write data viewed through each register layout
    entrylo_t    lo_w;
    context_t    ctx_w;
    entryhi_t    hi_w;
    status_t     st_w;
    cause_t      cause_w;

    logic        do_mtc0;
    logic        do_tlbwi;

    assign lo_w    = wdata;
    assign ctx_w   = wdata;
    assign hi_w    = wdata;
    assign st_w    = wdata;
    assign cause_w = wdata;

    // exception and eret outrank every op
    assign do_mtc0  = op.mtc0_en && !estate.take && !estate.ret;
    assign do_tlbwi = op.tlbwi && !op.mtc0_en && !estate.take && !estate.ret;

    assign tlb_we = do_tlbwi && !stall;
    assign tlb_wentry = '{
        VPN2: entryhi_q.VPN2,
        ASID: entryhi_q.ASID,
        G:    entrylo0_q.G & entrylo1_q.G,
        PFN0: entrylo0_q.PFN,
        C0:   entrylo0_q.C[0],
        D0:   entrylo0_q.D,
        V0:   entrylo0_q.V,
        PFN1: entrylo1_q.PFN,
        C1:   entrylo1_q.C[0],
        D1:   entrylo1_q.D,
        V1:   entrylo1_q.V
    };

    assign status   = status_q;
    assign epc      = epc_q;
    assign errorepc = errorepc_q;
    assign ebase    = ebase_q;
    assign entryhi  = entryhi_q;
    assign index    = index_q.index;

    // mfc0
    always_comb begin
        case (op.reg_addr)
            `CP0_REG_INDEX:      rdata = index_q;
            `CP0_REG_ENTRYLO0:   rdata = entrylo0_q;
            `CP0_REG_ENTRYLO1:   rdata = entrylo1_q;
            `CP0_REG_CONTEXT:    rdata = context_q;
            `CP0_REG_PAGEMASK:   rdata = 32'd0;
            `CP0_REG_BADVADDR:   rdata = badva_q;
            `CP0_REG_ENTRYHI:    rdata = entryhi_q;
            `CP0_REG_STATUS:     rdata = status_q;
            `CP0_REG_CAUSE:      rdata = cause_q;
            `CP0_REG_EPC:        rdata = epc_q;
            `CP0_REG_PRID_EBASE: rdata = (op.sel == 3'd0) ? `PRID_VALUE :
                                         (op.sel == 3'd1) ? ebase_q : 32'd0;
            `CP0_REG_CONFIG:     rdata = (op.sel == 3'd0) ? `CONFIG0_VALUE : 32'd0;
            `CP0_REG_ERREPC:     rdata = errorepc_q;
            default:             rdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index_q    <= '0;
            entrylo0_q <= '0;
            entrylo1_q <= '0;
            context_q  <= '0;
            badva_q    <= '0;
            entryhi_q  <= '0;
            status_q   <= '{BEV: 1'b1, default: '0};
            cause_q    <= '0;
            epc_q      <= '0;
            ebase_q    <= `EBASE_RESET;
            errorepc_q <= '0;
        end else if (!stall) begin
            if (estate.take) begin
                status_q.EXL    <= 1'b1;
                cause_q.exccode <= estate.exccode;
                // nested exceptions keep the first epc
                if (!status_q.EXL) begin
                    epc_q      <= estate.epc;
                    cause_q.BD <= estate.bd;
                end
                if (estate.set_badva) begin
                    badva_q <= estate.badva;
                end
                if (estate.set_vpn2) begin
                    context_q.badvpn2 <= estate.badva[31:13];
                    entryhi_q.VPN2    <= estate.badva[31:13];
                end
            end else if (estate.ret) begin
                if (status_q.ERL) begin
                    status_q.ERL <= 1'b0;
                end else begin
                    status_q.EXL <= 1'b0;
                end
            end else if (do_mtc0) begin
                case (op.reg_addr)
                    `CP0_REG_INDEX:    index_q.index <= wdata[`TLB_IDX_W-1:0];
                    `CP0_REG_ENTRYLO0: entrylo0_q <= '{PFN: lo_w.PFN, C: lo_w.C, D: lo_w.D,
                                                       V: lo_w.V, G: lo_w.G, default: '0};
                    `CP0_REG_ENTRYLO1: entrylo1_q <= '{PFN: lo_w.PFN, C: lo_w.C, D: lo_w.D,
                                                       V: lo_w.V, G: lo_w.G, default: '0};
                    `CP0_REG_CONTEXT:  context_q.ptebase <= ctx_w.ptebase;
                    `CP0_REG_ENTRYHI: begin
                        entryhi_q.VPN2 <= hi_w.VPN2;
                        entryhi_q.ASID <= hi_w.ASID;
                    end
                    `CP0_REG_STATUS: begin
                        status_q.CU0 <= st_w.CU0;
                        status_q.BEV <= st_w.BEV;
                        status_q.IM  <= st_w.IM;
                        status_q.UM  <= st_w.UM;
                        status_q.ERL <= st_w.ERL;
                        status_q.EXL <= st_w.EXL;
                        status_q.IE  <= st_w.IE;
                    end
                    // only the two software interrupt bits
                    `CP0_REG_CAUSE:    cause_q.IP[1:0] <= cause_w.IP[1:0];
                    `CP0_REG_EPC:      epc_q <= wdata;
                    `CP0_REG_PRID_EBASE: begin
                        if (op.sel == 3'd1) begin
                            ebase_q[29:0] <= wdata[29:0];
                        end
                    end
                    `CP0_REG_ERREPC:   errorepc_q <= wdata;
                    default: ;
                endcase
            end else if (do_tlbwi) begin
                // entry itself is written inside tlb_array
            end else if (op.tlbp) begin
                index_q.p <= !probe_hit;
                if (probe_hit) begin
                    index_q.index <= probe_index;
                end
            end else if (op.tlbr) begin
                entrylo0_q <= '{PFN: read_entry.PFN0, C: {2'b01, read_entry.C0},
                                D: read_entry.D0, V: read_entry.V0, G: read_entry.G,
                                default: '0};
                entrylo1_q <= '{PFN: read_entry.PFN1, C: {2'b01, read_entry.C1},
                                D: read_entry.D1, V: read_entry.V1, G: read_entry.G,
                                default: '0};
                entryhi_q.VPN2 <= read_entry.VPN2;
                entryhi_q.ASID <= read_entry.ASID;
            end
        end
    end

    tlb_op_onehot_a: assert property (@(posedge clk) disable iff (rst)
        $onehot0({op.tlbwi, op.tlbp, op.tlbr}));

endmodule

/* tlb/tlb_array.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module tlb_array import cp0_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [`TLB_IDX_W-1:0] windex,
    input  tlb_entry_t            wentry,
    input  logic [7:0]            asid,
    input  logic [18:0]           probe_vpn2,
    input  logic [18:0]           lookup_vpn2,
    input  logic [`TLB_IDX_W-1:0] rindex,
    output logic                  probe_hit,
    output logic [`TLB_IDX_W-1:0] probe_index,
    output logic                  lookup_found,
    output tlb_entry_t            lookup_entry,
    output tlb_entry_t            read_entry
);

    tlb_entry_t            entries [`TLB_ENTRIES];
    logic [`TLB_IDX_W-1:0] lookup_index;

    always_ff @(posedge clk) begin
        if (rst) begin
            entries <= '{default: '0};
        end else if (we) begin
            entries[windex] <= wentry;
        end
    end

    // tlbp against entryhi
    tlb_match u_probe_match (
        .entries (entries),
        .asid    (asid),
        .vpn2    (probe_vpn2),
        .hit     (probe_hit),
        .index   (probe_index)
    );

    // translation port
    tlb_match u_lookup_match (
        .entries (entries),
        .asid    (asid),
        .vpn2    (lookup_vpn2),
        .hit     (lookup_found),
        .index   (lookup_index)
    );

    assign lookup_entry = entries[lookup_index];
    assign read_entry   = entries[rindex];

endmodule

/* tlb/tlb_match.sv */
`timescale 1ns/1ns
`include "cp0_defs.svh"

module tlb_match import cp0_pkg::*; (
    input  tlb_entry_t            entries [`TLB_ENTRIES],
    input  logic [7:0]            asid,
    input  logic [18:0]           vpn2,
    output logic                  hit,
    output logic [`TLB_IDX_W-1:0] index
);

    logic [`TLB_ENTRIES-1:0] match;

    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_cmp
        assign match[i] = (entries[i].VPN2 == vpn2) &&
                          (entries[i].G || entries[i].ASID == asid);
    end

    assign hit = |match;

    // walk downwards so the lowest hit wins
    always_comb begin
        index = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                index = `TLB_IDX_W'(i);
            end
        end
    end

endmodule

/* common/cp0_pkg.sv */
`include "cp0_defs.svh"

package cp0_pkg;

    typedef struct packed {
        logic       mtc0_en;
        logic       eret;
        logic       tlbwi;
        logic       tlbp;
        logic       tlbr;
        logic [4:0] reg_addr;
        logic [2:0] sel;
    } cp0_op_t;

    typedef struct packed {
        logic if_adel;
        logic if_tlbl;
        logic if_tlbrf;
        logic ex_adel;
        logic ex_ades;
        logic ex_tlbl;
        logic ex_tlbs;
        logic ex_tlbm;
        logic ex_tlbrf;
        logic id_syscall;
        logic id_break;
        logic id_ri;
        logic id_cpu;
        logic ex_ov;
        logic ex_trap;
    } except_t;

    typedef struct packed {
        logic [5:0]  zero;
        logic [19:0] PFN;
        logic [2:0]  C;
        logic        D;
        logic        V;
        logic        G;
    } entrylo_t;

    typedef struct packed {
        logic [18:0] VPN2;
        logic [4:0]  zero;
        logic [7:0]  ASID;
    } entryhi_t;

    typedef struct packed {
        logic [2:0] zero3;
        logic       CU0;
        logic [4:0] zero2;
        logic       BEV;
        logic [5:0] zero1;
        logic [7:0] IM;
        logic [2:0] zero0;
        logic       UM;
        logic       zero;
        logic       ERL;
        logic       EXL;
        logic       IE;
    } status_t;

    typedef struct packed {
        logic        BD;
        logic [14:0] zero1;
        logic [7:0]  IP;
        logic        zero0;
        logic [4:0]  exccode;
        logic [1:0]  zero;
    } cause_t;

    typedef struct packed {
        logic                  p;
        logic [30-`TLB_IDX_W:0] zero;
        logic [`TLB_IDX_W-1:0] index;
    } index_t;

    typedef struct packed {
        logic [8:0]  ptebase;
        logic [18:0] badvpn2;
        logic [3:0]  zero;
    } context_t;

    // one even/odd page pair, 4KB pages only
    typedef struct packed {
        logic [18:0] VPN2;
        logic [7:0]  ASID;
        logic        G;
        logic [19:0] PFN0;
        logic        C0;
        logic        D0;
        logic        V0;
        logic [19:0] PFN1;
        logic        C1;
        logic        D1;
        logic        V1;
    } tlb_entry_t;

    // exception entry / return request towards the register file
    typedef struct packed {
        logic        take;
        logic        ret;
        logic [4:0]  exccode;
        logic        bd;
        logic [31:0] epc;
        logic        set_badva;
        logic        set_vpn2;
        logic [31:0] badva;
    } except_state_t;

endpackage

/* common/cp0_defs.svh */
`ifndef CP0_DEFS_SVH
`define CP0_DEFS_SVH

// tlb geometry
`define TLB_ENTRIES         8
`define TLB_IDX_W           3

// cp0 register numbers
`define CP0_REG_INDEX       5'd0
`define CP0_REG_ENTRYLO0    5'd2
`define CP0_REG_ENTRYLO1    5'd3
`define CP0_REG_CONTEXT     5'd4
`define CP0_REG_PAGEMASK    5'd5
`define CP0_REG_BADVADDR    5'd8
`define CP0_REG_ENTRYHI     5'd10
`define CP0_REG_STATUS      5'd12
`define CP0_REG_CAUSE       5'd13
`define CP0_REG_EPC         5'd14
`define CP0_REG_PRID_EBASE  5'd15
`define CP0_REG_CONFIG      5'd16
`define CP0_REG_ERREPC      5'd30

// exception codes written into cause.exccode
`define EXC_MOD             5'h01
`define EXC_TLBL            5'h02
`define EXC_TLBS            5'h03
`define EXC_ADEL            5'h04
`define EXC_ADES            5'h05
`define EXC_SYS             5'h08
`define EXC_BP              5'h09
`define EXC_RI              5'h0a
`define EXC_CPU             5'h0b
`define EXC_OV              5'h0c
`define EXC_TR              5'h0d

// vector bases and offsets
`define BOOT_TRAP_BASE      32'hbfc0_0200
`define EBASE_RESET         32'h8000_0000
`define VEC_REFILL          32'h0000_0000
`define VEC_GENERAL         32'h0000_0180

// read-only identification
`define PRID_VALUE          32'h0001_8003
// M=1, MT=1 (standard tlb), K0=3 (cacheable)
`define CONFIG0_VALUE       32'h8000_0083

`endif
